//--- logic/configBridge.sv
// Host configuration bridge
module configBridge (
	input logic clk,
	input logic rst,

	// Host side, four-phase handshake
	input logic cfgReq,
	input logic cfgWrite,
	input weightStreamPkg::addrT cfgAddr,
	input weightStreamPkg::weightT cfgWData,
	output logic cfgAck,
	output weightStreamPkg::weightT cfgRData,

	// Memory side, single-cycle commands
	output logic memCe,
	output logic memWe,
	output weightStreamPkg::addrT memAddr,
	output weightStreamPkg::weightT memWData,
	input logic memRack,
	input weightStreamPkg::weightT memRData
);

	// Current handshake phase
	logic [1:0] state;

	// Request captured at the rising edge of cfgReq
	logic writeReg;
	weightStreamPkg::addrT addrReg;
	weightStreamPkg::weightT dataReg;

	// ------------------------------
	// Handshake FSM
	// ------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= weightStreamPkg::bridgeIdle;
		end else begin
			case (state)
				// Wait for a new request
				weightStreamPkg::bridgeIdle: begin
					if (cfgReq) begin
						state <= weightStreamPkg::bridgeIssue;
					end
				end
				// One command cycle, writes complete right away
				weightStreamPkg::bridgeIssue: begin
					if (writeReg) begin
						state <= weightStreamPkg::bridgeAck;
					end else begin
						state <= weightStreamPkg::bridgeWaitRead;
					end
				end
				// Read-back in flight
				weightStreamPkg::bridgeWaitRead: begin
					if (memRack) begin
						state <= weightStreamPkg::bridgeAck;
					end
				end
				// Hold ack until host drops req
				default: begin
					if (!cfgReq) begin
						state <= weightStreamPkg::bridgeIdle;
					end
				end
			endcase
		end
	end

	// ------------------------------
	// Request and response data
	// ------------------------------

	// Latch host fields once per request
	always_ff @(posedge clk) begin
		if (state == weightStreamPkg::bridgeIdle && cfgReq) begin
			writeReg <= cfgWrite;
			addrReg <= cfgAddr;
			dataReg <= cfgWData;
		end
	end

	// Read-back word, valid while cfgAck is high
	always_ff @(posedge clk) begin
		if (memRack) begin
			cfgRData <= memRData;
		end
	end

	// Outputs decoded from state
	assign memCe = (state == weightStreamPkg::bridgeIssue);
	assign memWe = writeReg;
	assign memAddr = addrReg;
	assign memWData = dataReg;
	assign cfgAck = (state == weightStreamPkg::bridgeAck);

	// ------------------------------
	// Checks
	// ------------------------------

	// Exactly one command cycle per request
	memCeSingle: assert property (@(posedge clk) disable iff (rst)
		memCe |=> !memCe);

	// Memory answers only to an outstanding read
	rackInWait: assert property (@(posedge clk) disable iff (rst)
		memRack |-> state == weightStreamPkg::bridgeWaitRead);

endmodule

//--- logic/dotUnit.sv
// Dot product accumulator
module dotUnit (
	input logic clk,
	input logic rst,

	// Weight stream
	input logic wVld,
	output logic wRdy,
	input weightStreamPkg::weightT wDat,

	// Activation stream
	input logic aVld,
	output logic aRdy,
	input weightStreamPkg::actT aDat,

	// One sum per table pass
	output logic sVld,
	input logic sRdy,
	output weightStreamPkg::sumT sDat
);

	localparam int prodWidth = weightStreamPkg::weightWidth + weightStreamPkg::actWidth;

	// Pair handshake
	logic fire;
	logic blocked;
	logic lastPair;

	// Signed product of the current pair
	logic signed [prodWidth-1:0] prod;

	// Running sum and pair index within the pass
	weightStreamPkg::sumT acc;
	weightStreamPkg::addrT pairCnt;
	weightStreamPkg::sumT accNext;

	// ------------------------------
	// Pairing
	// ------------------------------

	// Untaken sum stops new pairs
	assign blocked = sVld && !sRdy;
	assign fire = wVld && aVld && !blocked;

	// Both sides accept together
	assign wRdy = fire;
	assign aRdy = fire;

	assign prod = wDat * aDat;
	// Sign extended into sum width
	assign accNext = acc + prod;
	assign lastPair = (pairCnt == weightStreamPkg::lastAddr);

	// ------------------------------
	// Accumulation
	// ------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
			pairCnt <= '0;
		end else if (fire) begin
			if (lastPair) begin
				// Start the next pass from zero
				acc <= '0;
				pairCnt <= '0;
			end else begin
				acc <= accNext;
				pairCnt <= pairCnt + 1'b1;
			end
		end
	end

	// ------------------------------
	// Result holding
	// ------------------------------

	// Valid until taken
	always_ff @(posedge clk) begin
		if (rst) begin
			sVld <= 1'b0;
		end else if (fire && lastPair) begin
			sVld <= 1'b1;
		end else if (sRdy) begin
			sVld <= 1'b0;
		end
	end

	// Completed sum
	always_ff @(posedge clk) begin
		if (fire && lastPair) begin
			sDat <= accNext;
		end
	end

	// Held sum stays put under back-pressure
	sumHeld: assert property (@(posedge clk) disable iff (rst)
		sVld && !sRdy |=> sVld && $stable(sDat));

endmodule

//--- logic/memStream.sv
// Weight memory streamer
module memStream (
	input logic clk,
	input logic rst,

	// Configuration port from the bridge
	input logic memCe,
	input logic memWe,
	input weightStreamPkg::addrT memAddr,
	input weightStreamPkg::weightT memWData,
	output logic memRack,
	output weightStreamPkg::weightT memRData,

	// Wrapping weight stream
	input logic wRdy,
	output logic wVld,
	output weightStreamPkg::weightT wDat
);

	// Pipeline advance
	logic en;
	// Withdraw stalled stream word
	logic rollback;
	logic backpressure;

	// Pointer history, entry 0 is the next read
	weightStreamPkg::addrT ptr0Val;
	logic ptr0Lst;
	weightStreamPkg::addrT ptr1Val;
	logic ptr1Lst;
	weightStreamPkg::addrT ptr2Val;
	logic ptr2Lst;

	// Stage 1 operation
	logic wr1;
	logic rb1;
	logic rs1;
	weightStreamPkg::weightT data1;

	// Stage 2 operation
	logic rb2;
	logic rs2;
	weightStreamPkg::weightT data2;

	// Table storage
	weightStreamPkg::weightT mem [weightStreamPkg::tableDepth];

	// ------------------------------
	// Stage 1 address and op
	// ------------------------------

	weightStreamPkg::addrT effVal;
	logic effLst;
	weightStreamPkg::addrT nxtVal;
	logic nxtLst;

	// Restart from the stalled word on rollback
	assign effVal = rollback ? ptr2Val : ptr0Val;
	assign effLst = rollback ? ptr2Lst : ptr0Lst;

	// Config slot keeps the pointer in place
	always_comb begin
		if (memCe) begin
			nxtVal = effVal;
			nxtLst = effLst;
		end else if (effLst) begin
			nxtVal = '0;
			nxtLst = 1'b0;
		end else begin
			nxtVal = effVal + 1'b1;
			nxtLst = (effVal == weightStreamPkg::preLastAddr);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr0Val <= '0;
			ptr0Lst <= 1'b0;
		end else if (en) begin
			ptr0Val <= nxtVal;
			ptr0Lst <= nxtLst;
		end
	end

	// Op flags
	always_ff @(posedge clk) begin
		if (rst) begin
			wr1 <= 1'b0;
			rb1 <= 1'b0;
			rs1 <= 1'b0;
		end else if (en) begin
			wr1 <= memCe && memWe;
			rb1 <= memCe && !memWe;
			rs1 <= !memCe;
		end
	end

	// Address and write data
	always_ff @(posedge clk) begin
		if (en) begin
			if (memCe) begin
				ptr1Val <= memAddr;
				ptr1Lst <= 1'b0;
			end else begin
				ptr1Val <= effVal;
				ptr1Lst <= effLst;
			end
			data1 <= memWData;
		end
	end

	// ------------------------------
	// Stage 2 memory access
	// ------------------------------

	// Read before write, one shared output register
	always_ff @(posedge clk) begin
		if (en) begin
			if (wr1) begin
				mem[ptr1Val] <= data1;
			end
			data2 <= mem[ptr1Val];
		end
	end

	// Stream word dropped when rolled back
	always_ff @(posedge clk) begin
		if (rst) begin
			rb2 <= 1'b0;
			rs2 <= 1'b0;
		end else if (en) begin
			rb2 <= rb1;
			rs2 <= rs1 && !rollback;
		end
	end

	// Keep pointer of the word in stage 2
	always_ff @(posedge clk) begin
		if (en) begin
			ptr2Val <= ptr1Val;
			ptr2Lst <= ptr1Lst;
		end
	end

	// ------------------------------
	// Outputs and flow control
	// ------------------------------

	assign memRack = rb2;
	assign memRData = data2;
	assign wVld = rs2;
	assign wDat = data2;

	assign backpressure = rs2 && !wRdy;
	// Config ops never wait behind a stalled stream
	assign rollback = backpressure && (memCe || wr1 || rb1);
	assign en = !backpressure || memCe || wr1 || rb1;

	// Read-back and stream share data2, never both
	rackVldExcl: assert property (@(posedge clk) disable iff (rst)
		!(memRack && wVld));

	// Stalled word held when no config op is around
	stallStable: assert property (@(posedge clk) disable iff (rst)
		wVld && !wRdy && !memCe && !wr1 && !rb1 |=> wVld && $stable(wDat));

endmodule

//--- logic/weightStreamPkg.sv
// Weight stream shared definitions
package weightStreamPkg;

	// ------------------------------
	// Table geometry
	// ------------------------------

	// Weights per pass
	localparam int tableDepth = 16;
	// Address bits for one table entry
	localparam int addrWidth = $clog2(tableDepth);

	// ------------------------------
	// Data widths
	// ------------------------------

	localparam int weightWidth = 8;
	localparam int actWidth = 8;
	// Room for 16 products of two 8-bit values
	localparam int sumWidth = 24;

	// ------------------------------
	// Word types
	// ------------------------------

	typedef logic signed [weightWidth-1:0] weightT;
	typedef logic [addrWidth-1:0] addrT;
	typedef logic signed [actWidth-1:0] actT;
	typedef logic signed [sumWidth-1:0] sumT;

	// Final and second to final table entries
	localparam addrT lastAddr = addrT'(tableDepth - 1);
	localparam addrT preLastAddr = addrT'(tableDepth - 2);

	// Configuration bridge state codes
	localparam logic [1:0] bridgeIdle = 2'd0;
	localparam logic [1:0] bridgeIssue = 2'd1;
	localparam logic [1:0] bridgeWaitRead = 2'd2;
	localparam logic [1:0] bridgeAck = 2'd3;

endpackage

//--- logic/weightStreamTop.sv
// Weight streaming subsystem
module weightStreamTop (
	input logic clk,
	input logic rst,

	// Host configuration port
	input logic cfgReq,
	input logic cfgWrite,
	input weightStreamPkg::addrT cfgAddr,
	input weightStreamPkg::weightT cfgWData,
	output logic cfgAck,
	output weightStreamPkg::weightT cfgRData,

	// Activation input stream
	input logic aVld,
	output logic aRdy,
	input weightStreamPkg::actT aDat,

	// Sum output stream
	output logic sVld,
	input logic sRdy,
	output weightStreamPkg::sumT sDat
);

	// ------------------------------
	// Bridge to memory commands
	// ------------------------------

	logic memCe;
	logic memWe;
	weightStreamPkg::addrT memAddr;
	weightStreamPkg::weightT memWData;
	logic memRack;
	weightStreamPkg::weightT memRData;

	// Weight stream into the dot unit
	logic wVld;
	logic wRdy;
	weightStreamPkg::weightT wDat;

	configBridge configBridge_inst (
		.clk(clk),
		.rst(rst),
		.cfgReq(cfgReq),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgWData(cfgWData),
		.cfgAck(cfgAck),
		.cfgRData(cfgRData),
		.memCe(memCe),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWData(memWData),
		.memRack(memRack),
		.memRData(memRData)
	);

	// ------------------------------
	// Weight table and streamer
	// ------------------------------

	memStream memStream_inst (
		.clk(clk),
		.rst(rst),
		.memCe(memCe),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWData(memWData),
		.memRack(memRack),
		.memRData(memRData),
		.wRdy(wRdy),
		.wVld(wVld),
		.wDat(wDat)
	);

	// ------------------------------
	// Pairing and accumulation
	// ------------------------------

	dotUnit dotUnit_inst (
		.clk(clk),
		.rst(rst),
		.wVld(wVld),
		.wRdy(wRdy),
		.wDat(wDat),
		.aVld(aVld),
		.aRdy(aRdy),
		.aDat(aDat),
		.sVld(sVld),
		.sRdy(sRdy),
		.sDat(sDat)
	);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the weight stream testbench with Verilator

buildDir=obj_dir
simName=weightStreamSim
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module weightStreamTb -f weightStream.f \
	--Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^TEST OK$" "$logFile"; then
	exit 0
fi
echo "Pass line not found in $logFile"
exit 1

//--- verification/clockGen.sv
// Testbench clock source
module clockGen (
	output logic clk
);

	// Half of the 40-unit period
	localparam int halfPeriod = 20;

	initial begin
		clk = 1'b0;
	end

	always #halfPeriod clk = ~clk;

endmodule

//--- verification/weightStreamTb.sv
// Weight stream testbench
module weightStreamTb;

	// Operation kinds in the stimulus table
	localparam int opWrite = 0;
	localparam int opRead = 1;
	localparam int opFrame = 2;
	localparam int opStallFrame = 3;

	localparam int rowCount = 31;
	localparam int resetCycles = 2;
	// Generous bound for the longest row
	localparam int rowBound = 80;
	localparam int cycleLimit = resetCycles + rowCount * rowBound;
	// Input drive offset after the rising edge
	localparam int driveDelay = 2;

	// Initial table load with one weight per address
	localparam weightStreamPkg::weightT loadWeights [16] = '{
		8'sd5, -8'sd3, 8'sd12, 8'sh80, 8'sd127, 8'sd0, -8'sd1, 8'sd64,
		-8'sd77, 8'sd33, 8'sd9, -8'sd20, 8'sd100, -8'sd50, 8'sd7, 8'sd1
	};

	logic clk;
	logic rst;
	logic cfgReq;
	logic cfgWrite;
	weightStreamPkg::addrT cfgAddr;
	weightStreamPkg::weightT cfgWData;
	logic cfgAck;
	weightStreamPkg::weightT cfgRData;
	logic aVld;
	logic aRdy;
	weightStreamPkg::actT aDat;
	logic sVld;
	logic sRdy;
	weightStreamPkg::sumT sDat;

	// Stimulus table columns
	string rowName [rowCount];
	int rowKind [rowCount];
	weightStreamPkg::addrT rowAddr [rowCount];
	weightStreamPkg::weightT rowData [rowCount];
	int rowStall [rowCount];

	// Mirror of the weight table
	weightStreamPkg::weightT modelWeights [weightStreamPkg::tableDepth];
	logic [31:0] lcgState = 32'h064f_fbeb;
	int cycleCount = 0;

	// Sum left waiting by a stalled sink
	weightStreamPkg::sumT heldSum;
	string heldName;
	int heldStall = 0;

	clockGen clockGen_inst (
		.clk(clk)
	);

	weightStreamTop weightStreamTop_inst (
		.clk(clk),
		.rst(rst),
		.cfgReq(cfgReq),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgWData(cfgWData),
		.cfgAck(cfgAck),
		.cfgRData(cfgRData),
		.aVld(aVld),
		.aRdy(aRdy),
		.aDat(aDat),
		.sVld(sVld),
		.sRdy(sRdy),
		.sDat(sDat)
	);

	// ------------------------------
	// Helpers
	// ------------------------------

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic failRun();
		$display("TEST FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic checkWeight(input string name, input weightStreamPkg::weightT expected,
			input weightStreamPkg::weightT actual);
		if (actual !== expected) begin
			$display("Error %s expected %0d actual %0d", name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkSum(input string name, input weightStreamPkg::sumT expected,
			input weightStreamPkg::sumT actual);
		if (actual !== expected) begin
			$display("Error %s expected %0d actual %0d", name, expected, actual);
			failRun();
		end
	endtask

	task automatic setRow(input int idx, input string name, input int kind,
			input weightStreamPkg::addrT addr, input weightStreamPkg::weightT data,
			input int stall);
		rowName[idx] = name;
		rowKind[idx] = kind;
		rowAddr[idx] = addr;
		rowData[idx] = data;
		rowStall[idx] = stall;
	endtask

	// One four-phase host access that ends with cfgAck low
	task automatic cfgAccess(input logic write, input weightStreamPkg::addrT addr,
			input weightStreamPkg::weightT wdata, output weightStreamPkg::weightT rdata);
		cfgReq = 1'b1;
		cfgWrite = write;
		cfgAddr = addr;
		cfgWData = wdata;
		@(negedge clk);
		while (!cfgAck) @(negedge clk);
		rdata = cfgRData;
		@(posedge clk);
		#driveDelay;
		cfgReq = 1'b0;
		@(negedge clk);
		while (!cfgAck) begin
			break;
		end
		while (cfgAck) @(negedge clk);
		@(posedge clk);
		#driveDelay;
	endtask

	// Held sum blocks the offered activation until the sink frees up
	task automatic drainHeldSum();
		repeat (heldStall) begin
			@(negedge clk);
			if (!sVld) begin
				$display("Sum valid dropped while the sink was stalled in %s", heldName);
				failRun();
			end
			if (aRdy) begin
				$display("Activation accepted while a sum was held in %s", heldName);
				failRun();
			end
			checkSum(heldName, heldSum, sDat);
		end
		@(posedge clk);
		#driveDelay;
		sRdy = 1'b1;
		heldStall = 0;
	endtask

	// Sixteen activations and then the pass sum
	task automatic runFrame(input string name, input int stallCycles);
		weightStreamPkg::sumT expected;
		weightStreamPkg::actT act;
		int k;
		expected = '0;
		if (stallCycles > 0) begin
			sRdy = 1'b0;
		end
		for (k = 0; k < weightStreamPkg::tableDepth; k++) begin
			lcgState = lcgNext(lcgState);
			act = weightStreamPkg::actT'(lcgState[23:16]);
			// Pass k pairs with address k
			expected = expected + weightStreamPkg::sumT'(modelWeights[k])
				* weightStreamPkg::sumT'(act);
			aVld = 1'b1;
			aDat = act;
			// First activation waits behind an untaken sum
			if (heldStall > 0) begin
				drainHeldSum();
			end
			@(negedge clk);
			while (!aRdy) @(negedge clk);
			@(posedge clk);
			#driveDelay;
		end
		aVld = 1'b0;
		@(negedge clk);
		while (!sVld) @(negedge clk);
		checkSum(name, expected, sDat);
		// Stalled sink keeps the sum into the next frame
		if (stallCycles > 0) begin
			heldSum = expected;
			heldName = name;
			heldStall = stallCycles;
		end
		@(posedge clk);
		#driveDelay;
	endtask

	// ------------------------------
	// Run limit
	// ------------------------------

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles without finishing the table", cycleLimit);
			failRun();
		end
	end

	// ------------------------------
	// Stimulus table and main loop
	// ------------------------------

	initial begin
		int r;
		weightStreamPkg::weightT rdata;
		rst = 1'b1;
		cfgReq = 1'b0;
		cfgWrite = 1'b0;
		cfgAddr = '0;
		cfgWData = '0;
		aVld = 1'b0;
		aDat = '0;
		sRdy = 1'b1;

		// Full load and then spot reads
		for (r = 0; r < weightStreamPkg::tableDepth; r++) begin
			setRow(r, "load", opWrite, weightStreamPkg::addrT'(r), loadWeights[r], 0);
		end
		setRow(16, "readback addr 0", opRead, 4'd0, 8'sd5, 0);
		setRow(17, "readback addr 3", opRead, 4'd3, 8'sh80, 0);
		setRow(18, "readback addr 9", opRead, 4'd9, 8'sd33, 0);
		setRow(19, "readback addr 15", opRead, 4'd15, 8'sd1, 0);
		setRow(20, "first frame", opFrame, 4'd0, 8'sd0, 0);
		// Back to back passes
		setRow(21, "wrap frame a", opFrame, 4'd0, 8'sd0, 0);
		setRow(22, "wrap frame b", opFrame, 4'd0, 8'sd0, 0);
		// Rewrites hit the stalled word at address 0 too
		setRow(23, "rewrite", opWrite, 4'd2, -8'sd90, 0);
		setRow(24, "rewrite", opWrite, 4'd0, 8'sd55, 0);
		setRow(25, "rewrite", opWrite, 4'd15, 8'sh80, 0);
		setRow(26, "after rewrite", opFrame, 4'd0, 8'sd0, 0);
		setRow(27, "sink stall", opStallFrame, 4'd0, 8'sd0, 6);
		setRow(28, "after stall", opFrame, 4'd0, 8'sd0, 0);
		setRow(29, "stalled readback", opRead, 4'd0, 8'sd55, 0);
		setRow(30, "after readback", opFrame, 4'd0, 8'sd0, 0);

		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rst = 1'b0;

		for (r = 0; r < rowCount; r++) begin
			case (rowKind[r])
				opWrite: begin
					cfgAccess(1'b1, rowAddr[r], rowData[r], rdata);
					modelWeights[rowAddr[r]] = rowData[r];
				end
				opRead: begin
					cfgAccess(1'b0, rowAddr[r], '0, rdata);
					checkWeight(rowName[r], rowData[r], rdata);
				end
				default: begin
					runFrame(rowName[r], rowStall[r]);
				end
			endcase
		end

		$display("TEST OK");
		$finish;
	end

endmodule

//--- weightStream.f
logic/weightStreamPkg.sv
logic/configBridge.sv
logic/memStream.sv
logic/dotUnit.sv
logic/weightStreamTop.sv
verification/clockGen.sv
verification/weightStreamTb.sv
